//--- Bender.yml
package:
  name: rr_tree_arbiter

# top level: rr_tree_arbiter
# testbench top: tb_rr_tree_arbiter

sources:
  # design, package first
  - files:
      - rtl/arb_pkg.sv
      - rtl/group_selector.sv
      - rtl/member_arbiter.sv
      - rtl/rr_tree_arbiter.sv

  # simulation only
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_rr_tree_arbiter.sv

//--- rtl/arb_pkg.sv
`default_nettype none

package arb_pkg;

    // tree geometry
    localparam int GROUP_NUM     = 4;
    localparam int GROUP_WIDTH   = 4;
    localparam int ARBITER_WIDTH = GROUP_NUM * GROUP_WIDTH;
    localparam int PTR_WIDTH     = 2;

    // one bit per requester, group g owns bits 4g..4g+3
    typedef logic [ARBITER_WIDTH-1:0] req_vec_t;

    // one bit per group
    typedef logic [GROUP_NUM-1:0] group_vec_t;

    // one bit per member inside a group
    typedef logic [GROUP_WIDTH-1:0] member_vec_t;

    // binary member index for pointer and encoded grant
    typedef logic [PTR_WIDTH-1:0] member_idx_t;

    // what the group selector hands to one member arbiter
    typedef struct packed {
        member_vec_t req;
        logic        sel;
    } member_port_t;

    // indexed by group number
    typedef member_port_t [GROUP_NUM-1:0] member_port_arr_t;

endpackage

`default_nettype wire

//--- rtl/group_selector.sv
`default_nettype none
`timescale 1ns/1ps

module group_selector (
    input  logic                      clk,
    input  logic                      reset,
    input  arb_pkg::req_vec_t         request,
    output arb_pkg::member_port_arr_t member_ports,
    output logic                      any_grant
);

    import arb_pkg::*;

    // per group request summary
    group_vec_t group_req;

    // priority mask, ones above the last selected group
    group_vec_t prio_mask;
    group_vec_t masked_req;

    // thermometer codes of raw and masked requests
    group_vec_t thermo_raw;
    group_vec_t thermo_masked;
    group_vec_t thermo_sel;

    // chosen code shifted up by one, also the next mask
    group_vec_t edge_mask;

    // one-hot winning group
    group_vec_t group_sel;

    // bit i set when any of bits 0..i is set
    function automatic group_vec_t thermo_code(input group_vec_t in_vec);
        group_vec_t code;
        code[0] = in_vec[0];
        for (int i = 1; i < GROUP_NUM; i++) begin
            code[i] = code[i-1] | in_vec[i];
        end
        return code;
    endfunction

    always_comb begin
        for (int g = 0; g < GROUP_NUM; g++) begin
            group_req[g] = |request[g*GROUP_WIDTH +: GROUP_WIDTH];
        end
    end

    assign masked_req    = group_req & prio_mask;
    assign thermo_raw    = thermo_code(group_req);
    assign thermo_masked = thermo_code(masked_req);

    // masked code wins when some group above the last winner requests
    assign thermo_sel = thermo_masked[GROUP_NUM-1] ? thermo_masked : thermo_raw;

    assign edge_mask = {thermo_sel[GROUP_NUM-2:0], 1'b0};

    // rising edge of the thermometer code marks the winner
    assign group_sel = thermo_sel ^ edge_mask;

    assign any_grant = thermo_raw[GROUP_NUM-1];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prio_mask <= '1;
        end else if (any_grant) begin
            prio_mask <= edge_mask;
        end
    end

    // fan out slices and select bits to the member arbiters
    always_comb begin
        for (int g = 0; g < GROUP_NUM; g++) begin
            member_ports[g].req = request[g*GROUP_WIDTH +: GROUP_WIDTH];
            member_ports[g].sel = group_sel[g];
        end
    end

    // at most one group wins
    a_sel_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(group_sel)
    );

    // a winner exists exactly when some group requests
    a_sel_any: assert property (
        @(posedge clk) disable iff (reset)
        (|group_sel) == any_grant
    );

    // the winning group must be requesting
    a_sel_has_req: assert property (
        @(posedge clk) disable iff (reset)
        (group_sel & ~group_req) == '0
    );

    // after a win the mask holds only the groups above the winner
    a_mask_follows: assert property (
        @(posedge clk) disable iff (reset)
        any_grant |=> prio_mask == ~($past(group_sel) | ($past(group_sel) - 1'b1))
    );

endmodule

`default_nettype wire

//--- rtl/member_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module member_arbiter (
    input  logic                  clk,
    input  logic                  reset,
    input  arb_pkg::member_port_t port,
    output arb_pkg::member_vec_t  grant
);

    import arb_pkg::*;

    // last granted member, lowest priority next time
    member_idx_t low_pr;

    // rotating pick before the group select is applied
    member_vec_t pick;
    member_idx_t scan_idx;
    logic        found;

    // binary form of the grant, loaded into the pointer
    member_idx_t grant_bin;

    // or of the indices of all set bits, exact for one-hot input
    function automatic member_idx_t onehot_to_bin(input member_vec_t onehot);
        member_idx_t bin;
        bin = '0;
        for (int i = 0; i < GROUP_WIDTH; i++) begin
            if (onehot[i]) begin
                bin = bin | member_idx_t'(i);
            end
        end
        return bin;
    endfunction

    // search order low_pr+1, low_pr+2, low_pr+3, low_pr
    always_comb begin
        pick     = '0;
        found    = 1'b0;
        scan_idx = '0;
        for (int k = 1; k <= GROUP_WIDTH; k++) begin
            // 2-bit add wraps modulo four
            scan_idx = low_pr + member_idx_t'(k);
            if (!found && port.req[scan_idx]) begin
                pick[scan_idx] = 1'b1;
                found          = 1'b1;
            end
        end
    end

    // only the selected group drives a grant
    assign grant = port.sel ? pick : '0;

    assign grant_bin = onehot_to_bin(grant);

    // pointer moves only while this group wins
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            low_pr <= '0;
        end else if (port.sel) begin
            low_pr <= grant_bin;
        end
    end

    // never more than one member granted
    a_grant_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(grant)
    );

    // grants only go to requesting members
    a_grant_in_req: assert property (
        @(posedge clk) disable iff (reset)
        (grant & ~port.req) == '0
    );

    // a selected group always has a request, so someone gets through
    a_sel_grants: assert property (
        @(posedge clk) disable iff (reset)
        port.sel |-> (grant != '0)
    );

endmodule

`default_nettype wire

//--- rtl/rr_tree_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module rr_tree_arbiter (
    input  logic              clk,
    input  logic              reset,
    input  arb_pkg::req_vec_t request,
    output arb_pkg::req_vec_t grant,
    output logic              any_grant
);

    import arb_pkg::*;

    // request slices and select bits, one entry per group
    member_port_arr_t member_ports;

    // grant of each member arbiter, indexed by group
    member_vec_t [GROUP_NUM-1:0] member_grant;

    // picks one group per cycle
    group_selector u_group_selector (
        .clk          (clk),
        .reset        (reset),
        .request      (request),
        .member_ports (member_ports),
        .any_grant    (any_grant)
    );

    for (genvar g = 0; g < GROUP_NUM; g++) begin : g_member

        // picks one requester inside group g
        member_arbiter u_member (
            .clk   (clk),
            .reset (reset),
            .port  (member_ports[g]),
            .grant (member_grant[g])
        );

        // group g fills its own slice of the grant vector
        assign grant[g*GROUP_WIDTH +: GROUP_WIDTH] = member_grant[g];

    end

    // selector and member arbiters agree on whether a grant went out
    a_any_matches_grant: assert property (
        @(posedge clk) disable iff (reset)
        any_grant == (|grant)
    );

    // a held request with nothing else pending is served at once
    a_single_req_served: assert property (
        @(posedge clk) disable iff (reset)
        $onehot(request) |-> (grant == request)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    // half of the 40 ns period
    localparam int HALF_PERIOD_NS = 20;

    // low first, so the first rising edge lands at 20 ns
    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_rr_tree_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module tb_rr_tree_arbiter;

    import arb_pkg::*;

    // phase lengths in clock cycles
    localparam int RESET_CYCLES  = 16;
    localparam int SINGLE_CYCLES = 2 * ARBITER_WIDTH;
    localparam int GROUP_CYCLES  = 20;
    localparam int MEMBER_CYCLES = 32;
    localparam int FULL_CYCLES   = 64;
    localparam int RANDOM_CYCLES = 800;
    localparam int TAIL_CYCLES   = 4;
    localparam int TIMEOUT_LIMIT = RESET_CYCLES + SINGLE_CYCLES + GROUP_CYCLES
                                 + MEMBER_CYCLES + FULL_CYCLES + RANDOM_CYCLES
                                 + TAIL_CYCLES + 200;

    // fairness window, one grant per requester
    localparam int WINDOW = ARBITER_WIDTH;

    typedef enum logic [2:0] {
        PH_RESET,
        PH_SINGLE,
        PH_GROUP,
        PH_MEMBER,
        PH_FULL,
        PH_RANDOM,
        PH_TAIL
    } phase_t;

    logic     clk;
    logic     reset;
    req_vec_t request;
    req_vec_t grant;
    logic     any_grant;
    phase_t   phase;

    // reference model state
    int         model_group_ptr;
    int         model_member_ptr [GROUP_NUM];
    group_vec_t model_group_req;
    int         model_group;
    int         model_member;
    req_vec_t   model_grant;

    // sliding window of recent grants
    req_vec_t    grant_hist [WINDOW];
    req_vec_t    window_or;
    int          window_count;
    int          full_load_cycles;
    int unsigned cycle_count = 0;

    tb_clock_gen u_clock_gen (
        .clk (clk)
    );

    rr_tree_arbiter i_dut (
        .clk       (clk),
        .reset     (reset),
        .request   (request),
        .grant     (grant),
        .any_grant (any_grant)
    );

    function automatic string phase_label(input phase_t ph);
        case (ph)
            PH_RESET:  return "reset";
            PH_SINGLE: return "single request";
            PH_GROUP:  return "group rotation";
            PH_MEMBER: return "member rotation";
            PH_FULL:   return "full load";
            PH_RANDOM: return "random traffic";
            default:   return "tail";
        endcase
    endfunction

    // first set bit after position last, wrapping, last itself comes at the end
    function automatic int first_after(input logic [3:0] vec, input int last);
        int pick;
        int idx;
        pick = -1;
        for (int k = 1; k <= 4; k++) begin
            idx = (last + k) % 4;
            if (pick < 0 && vec[idx]) begin
                pick = idx;
            end
        end
        return pick;
    endfunction

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("CHECK FAILED %s (%s): expected 0x%04h, actual 0x%04h",
                 test, what, expected, actual);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_violation(input string test, input string what);
        $display("ERROR in %s: %s", test, what);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    // hold one request vector for a number of cycles
    task automatic hold_request(input req_vec_t value, input int cycles);
        @(posedge clk);
        request <= value;
        repeat (cycles - 1) @(posedge clk);
    endtask

    task automatic enter_phase(input phase_t ph);
        @(posedge clk);
        phase <= ph;
    endtask

    // expected grant from the model pointers and the current request
    always_comb begin
        for (int g = 0; g < GROUP_NUM; g++) begin
            model_group_req[g] = |request[g*GROUP_WIDTH +: GROUP_WIDTH];
        end
        model_group  = first_after(model_group_req, model_group_ptr);
        model_member = 0;
        model_grant  = '0;
        if (model_group >= 0) begin
            model_member = first_after(request[model_group*GROUP_WIDTH +: GROUP_WIDTH],
                                       model_member_ptr[model_group]);
            model_grant[model_group*GROUP_WIDTH + model_member] = 1'b1;
        end
    end

    // last group 3 means the search starts at group 0
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            model_group_ptr <= GROUP_NUM - 1;
            for (int g = 0; g < GROUP_NUM; g++) begin
                model_member_ptr[g] <= 0;
            end
        end else if (model_group >= 0) begin
            model_group_ptr               <= model_group;
            model_member_ptr[model_group] <= model_member;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = WINDOW - 1; i > 0; i--) begin
            grant_hist[i] <= grant_hist[i-1];
        end
        grant_hist[0] <= grant;
        if (request == '1) begin
            full_load_cycles <= full_load_cycles + 1;
        end else begin
            full_load_cycles <= 0;
        end
    end

    always_comb begin
        window_or    = '0;
        window_count = 0;
        for (int i = 0; i < WINDOW; i++) begin
            window_or    = window_or | grant_hist[i];
            window_count = window_count + $countones(grant_hist[i]);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_LIMIT) begin
            $display("ERROR: run exceeded %0d cycles without finishing", TIMEOUT_LIMIT);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    a_grant_onehot: assert property (@(posedge clk) $onehot0(grant))
        else report_violation(phase_label($sampled(phase)),
                              "grant has more than one bit set");

    a_grant_subset: assert property (@(posedge clk) (grant & ~request) == '0)
        else report_mismatch(phase_label($sampled(phase)), "grant outside request",
                             32'h0, $sampled(grant & ~request));

    a_any_grant: assert property (@(posedge clk) any_grant == (|request))
        else report_mismatch(phase_label($sampled(phase)), "any_grant",
                             $sampled(|request), $sampled(any_grant));

    // a lone request is answered in the same cycle
    a_single_served: assert property (
        @(posedge clk)
        (!reset && $onehot(request)) |-> (grant == request)
    ) else report_mismatch(phase_label($sampled(phase)), "single request grant",
                           $sampled(request), $sampled(grant));

    a_grant_model: assert property (@(posedge clk) grant == model_grant)
        else report_mismatch(phase_label($sampled(phase)), "grant vs model",
                             $sampled(model_grant), $sampled(grant));

    // 16 one-hot grants covering all 16 lines means each line exactly once
    a_window_fair: assert property (
        @(posedge clk)
        (full_load_cycles >= WINDOW) |-> (window_or == '1 && window_count == WINDOW)
    ) else report_mismatch(phase_label($sampled(phase)), "lines served in window",
                           32'h0000ffff, $sampled(window_or));

    initial begin
        req_vec_t value;
        request <= '0;
        reset   <= 1'b1;
        phase   <= PH_RESET;
        void'($urandom(32'h7cff));

        // random requests while reset holds the pointers
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            request <= req_vec_t'($urandom);
        end
        @(posedge clk);
        reset   <= 1'b0;
        request <= '0;

        enter_phase(PH_SINGLE);
        for (int i = 0; i < ARBITER_WIDTH; i++) begin
            hold_request(req_vec_t'(1) << i, 1);
            hold_request('0, 1);
        end

        // groups 0, 2 and 3, then 1 and 3, then 0 and 1
        enter_phase(PH_GROUP);
        hold_request(16'h4202, 9);
        hold_request(16'h8040, 6);
        hold_request(16'h0088, 5);

        // group 0 full, sharing with group 1
        enter_phase(PH_MEMBER);
        hold_request(16'h002f, 16);
        // group 0 idle, its pointer must stay put
        hold_request(16'h0200, 3);
        hold_request(16'h000f, 4);
        hold_request(16'h00af, 9);

        enter_phase(PH_FULL);
        hold_request('1, FULL_CYCLES);

        enter_phase(PH_RANDOM);
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            value = req_vec_t'($urandom);
            // thin out some vectors so sparse patterns show up too
            if ($urandom_range(0, 2) == 0) begin
                value = value & req_vec_t'($urandom) & req_vec_t'($urandom);
            end
            hold_request(value, 1);
        end

        enter_phase(PH_TAIL);
        hold_request('0, TAIL_CYCLES);
        @(posedge clk);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
rtl/arb_pkg.sv
rtl/group_selector.sv
rtl/member_arbiter.sv
rtl/rr_tree_arbiter.sv
testbench/tb_clock_gen.sv
testbench/tb_rr_tree_arbiter.sv
